// File: sim.f
design/constants.sv
design/wires.sv
design/mem_if.sv
design/memory_stage.sv
design/load_store_unit.sv
design/write_buffer.sv
design/memory_subsystem.sv
test/memory_assertions.sv
test/tb_memory_subsystem.sv

// File: test/tb_memory_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_memory_subsystem;
  import constants::*;

  logic clk;
  logic rst = 1'b0;
  logic in_valid = 1'b0;
  logic in_ready;
  logic flush = 1'b0;
  logic in_wren = 1'b0;
  logic [reg_addr_w-1:0] in_waddr = '0;
  logic in_load = 1'b0;
  logic in_store = 1'b0;
  logic in_fence = 1'b0;
  logic [xlen-1:0] in_address = '0;
  logic [xlen-1:0] in_sdata = '0;
  logic [xlen-1:0] in_wdata = '0;
  lsu_op_type in_lsu_op = '0;
  logic reg_wren;
  logic [reg_addr_w-1:0] reg_waddr;
  logic [xlen-1:0] reg_wdata;

  lsu_op_type op_lb = '{lsu_lb: 1'b1, default: 1'b0};
  lsu_op_type op_lh = '{lsu_lh: 1'b1, default: 1'b0};
  lsu_op_type op_lw = '{lsu_lw: 1'b1, default: 1'b0};
  lsu_op_type op_lbu = '{lsu_lbu: 1'b1, default: 1'b0};
  lsu_op_type op_lhu = '{lsu_lhu: 1'b1, default: 1'b0};
  lsu_op_type op_sb = '{lsu_sb: 1'b1, default: 1'b0};
  lsu_op_type op_sh = '{lsu_sh: 1'b1, default: 1'b0};
  lsu_op_type op_sw = '{lsu_sw: 1'b1, default: 1'b0};

  logic [15:0] lfsr = 16'd43;
  int timeout_cycles = 40;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int assert_fails;
  logic timed_out = 1'b0;

  memory_subsystem u_memory_subsystem (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [xlen-1:0] rand_bits(input int n);
    logic [xlen-1:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = {val[xlen-2:0], lfsr[15]};
    end
    return val;
  endfunction

  // ##########################################################################
  // drive and compare.
  // ##########################################################################

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_high(input bit for_write, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while ((for_write ? reg_wren : in_ready) !== 1'b1 && !timed_out) begin
      if (n == timeout_cycles) begin
        $display("timeout at %0t: %s stayed low for %0d cycles", $time, what, n);
        timed_out = 1'b1;
      end else begin
        n++;
        @(negedge clk);
      end
    end
  endtask

  task automatic issue(input logic wren, input logic [reg_addr_w-1:0] waddr,
                       input logic load, input logic store, input logic [xlen-1:0] address,
                       input logic [xlen-1:0] data, input lsu_op_type op);
    in_valid = 1'b1;
    in_wren = wren;
    in_waddr = waddr;
    in_load = load;
    in_store = store;
    in_address = address;
    in_sdata = data;
    in_wdata = data;
    in_lsu_op = op;
    wait_high(1'b0, "in_ready");
    step(); // accepted at this edge.
    in_valid = 1'b0;
  endtask

  task automatic compare_write(input logic exp_wren, input logic [reg_addr_w-1:0] exp_addr,
                               input logic [xlen-1:0] exp_data);
    if (timed_out) return;
    if (reg_wren !== exp_wren) begin
      $display("Error at %0t: reg_wren is %b, expected %b", $time, reg_wren, exp_wren);
      errors++;
    end else if (exp_wren && (reg_waddr !== exp_addr || reg_wdata !== exp_data)) begin
      $display("Error at %0t: wrote x%0d = %h, expected x%0d = %h", $time,
               reg_waddr, reg_wdata, exp_addr, exp_data);
      errors++;
    end
  endtask

  task automatic ready_check(input logic expected);
    if (timed_out) return;
    if (in_ready !== expected) begin
      $display("Error at %0t: in_ready is %b, expected %b", $time, in_ready, expected);
      errors++;
    end
  endtask

  task automatic load_check(input lsu_op_type op, input logic [xlen-1:0] address,
                            input logic [xlen-1:0] expected, input logic stalls);
    issue(1'b1, 5'd9, 1'b1, 1'b0, address, '0, op);
    if (stalls) begin
      @(negedge clk);
      ready_check(1'b0); // still behind a buffered store.
    end
    wait_high(1'b1, "reg_wren");
    compare_write(1'b1, 5'd9, expected);
    step();
  endtask

  task automatic report(input string name, input int e0);
    tests_run++;
    if (errors != e0 || timed_out) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - e0);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // ##########################################################################
  // directed tests.
  // ##########################################################################

  task automatic alu_writeback();
    int e0;
    logic [xlen-1:0] d;
    e0 = errors;
    @(negedge clk);
    ready_check(1'b1); // stage empty after reset.
    compare_write(1'b0, '0, '0);
    step();
    d = rand_bits(32);
    issue(1'b1, 5'd5, 1'b0, 1'b0, '0, d, '0);
    @(negedge clk);
    compare_write(1'b1, 5'd5, d);
    step();
    issue(1'b1, 5'd0, 1'b0, 1'b0, '0, d, '0);
    @(negedge clk);
    compare_write(1'b0, '0, '0);
    step();
    report("alu writeback", e0);
  endtask

  task automatic word_round_trip();
    int e0;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] d;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      addr = rand_bits(8) << 2;
      d = rand_bits(32);
      issue(1'b0, '0, 1'b0, 1'b1, addr, d, op_sw);
      load_check(op_lw, addr, d, 1'b1);
    end
    report("word round trip", e0);
  endtask

  task automatic partial_store_merge();
    int e0;
    word_lanes_type exp;
    logic [xlen-1:0] s;
    e0 = errors;
    exp = rand_bits(32);
    issue(1'b0, '0, 1'b0, 1'b1, 32'h40, exp, op_sw);
    s = rand_bits(32);
    issue(1'b0, '0, 1'b0, 1'b1, 32'h41, s, op_sb);
    exp.lane_b[1] = s[7:0];
    s = rand_bits(32);
    issue(1'b0, '0, 1'b0, 1'b1, 32'h42, s, op_sh);
    exp.lane_h[1] = s[15:0];
    s = rand_bits(32);
    issue(1'b0, '0, 1'b0, 1'b1, 32'h43, s, op_sb); // overwrites part of the halfword.
    exp.lane_b[3] = s[7:0];
    load_check(op_lw, 32'h40, exp, 1'b1);
    report("partial store merge", e0);
  endtask

  task automatic load_extension();
    int e0;
    word_lanes_type w;
    e0 = errors;
    w = 32'hf08e_7a95; // mixed sign bits across lanes.
    issue(1'b0, '0, 1'b0, 1'b1, 32'h80, w, op_sw);
    for (int i = 0; i < 4; i++) begin
      load_check(op_lb, 32'h80 + i, {{24{w.lane_b[i][7]}}, w.lane_b[i]}, 1'b0);
      load_check(op_lbu, 32'h80 + i, {24'h0, w.lane_b[i]}, 1'b0);
    end
    for (int i = 0; i < 2; i++) begin
      load_check(op_lh, 32'h80 + 2 * i, {{16{w.lane_h[i][15]}}, w.lane_h[i]}, 1'b0);
      load_check(op_lhu, 32'h80 + 2 * i, {16'h0, w.lane_h[i]}, 1'b0);
    end
    report("load extension", e0);
  endtask

  task automatic store_burst();
    int e0;
    logic [xlen-1:0] data [wb_depth + 2];
    e0 = errors;
    for (int i = 0; i < wb_depth + 2; i++) begin
      data[i] = rand_bits(32);
      issue(1'b0, '0, 1'b0, 1'b1, 32'h100 + 4 * i, data[i], op_sw);
    end
    for (int i = 0; i < wb_depth + 2; i++) begin
      load_check(op_lw, 32'h100 + 4 * i, data[i], i == 0);
    end
    report("store burst", e0);
  endtask

  task automatic flush_stalled_load();
    int e0;
    logic [xlen-1:0] d;
    e0 = errors;
    issue(1'b0, '0, 1'b0, 1'b1, 32'hc0, rand_bits(32), op_sw);
    issue(1'b1, 5'd9, 1'b1, 1'b0, 32'hc0, '0, op_lw);
    flush = 1'b1; // load waits for the buffer here.
    @(negedge clk);
    ready_check(1'b0);
    compare_write(1'b0, '0, '0);
    step();
    flush = 1'b0;
    repeat (3) begin
      @(negedge clk);
      compare_write(1'b0, '0, '0);
    end
    step();
    d = rand_bits(32);
    issue(1'b1, 5'd12, 1'b0, 1'b0, '0, d, '0);
    @(negedge clk);
    compare_write(1'b1, 5'd12, d);
    step();
    report("flush stalled load", e0);
  endtask

  initial begin
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;
    alu_writeback();
    if (!timed_out) word_round_trip();
    if (!timed_out) partial_store_merge();
    if (!timed_out) load_extension();
    if (!timed_out) store_burst();
    if (!timed_out) flush_stalled_load();
    assert_fails = u_memory_subsystem.u_memory_stage.u_memory_stage_assertions.fail_count;
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/memory_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage_assertions (
  input logic clk,
  input logic rst,
  input logic flush,
  input logic in_valid,
  input logic in_ready,
  input logic [constants::reg_addr_w-1:0] in_waddr,
  input logic reg_wren,
  input logic [constants::reg_addr_w-1:0] reg_waddr,
  input logic mem_valid,
  input logic mem_ready,
  input logic mem_fence,
  input logic [constants::xlen-1:0] mem_addr,
  input logic [constants::xlen-1:0] mem_wdata,
  input logic [constants::strb_w-1:0] mem_wstrb
);
  import constants::*;

  int fail_count = 0;
  logic [reg_addr_w-1:0] accepted_waddr;

  // destination of the instruction now held by the stage.
  always_ff @(posedge clk) begin
    if (rst == 0) begin
      accepted_waddr <= '0;
    end else if (in_valid && in_ready) begin
      accepted_waddr <= in_waddr;
    end
  end

  // x0 is hardwired to zero.
  no_x0_write: assert property (@(posedge clk) disable iff (!rst)
    reg_wren |-> accepted_waddr != '0 && reg_waddr == accepted_waddr) else begin
    fail_count++;
    $error("register write aimed at x0");
  end

  request_held: assert property (@(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready && !flush |=> mem_valid && $stable(mem_addr)
      && $stable(mem_wdata) && $stable(mem_wstrb) && $stable(mem_fence)) else begin
    fail_count++;
    $error("pending memory request changed before ready");
  end

  stall_blocks_input: assert property (@(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready |-> !in_ready) else begin
    fail_count++;
    $error("in_ready high while the stage is stalled");
  end

endmodule

bind memory_stage memory_stage_assertions u_memory_stage_assertions (
  .clk       (clk),
  .rst       (rst),
  .flush     (flush),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .in_waddr  (in_instr.waddr),
  .reg_wren  (reg_wren),
  .reg_waddr (reg_waddr),
  .mem_valid (mem.mem_valid),
  .mem_ready (mem.mem_ready),
  .mem_fence (mem.mem_fence),
  .mem_addr  (mem.mem_addr),
  .mem_wdata (mem.mem_wdata),
  .mem_wstrb (mem.mem_wstrb)
);

`default_nettype wire

// File: design/memory_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module memory_subsystem (
  input logic clk,
  input logic rst,
  input logic in_valid,
  output logic in_ready,
  input logic flush,
  input logic in_wren,
  input logic [constants::reg_addr_w-1:0] in_waddr,
  input logic in_load,
  input logic in_store,
  input logic in_fence,
  input logic [constants::xlen-1:0] in_address,
  input logic [constants::xlen-1:0] in_sdata,
  input logic [constants::xlen-1:0] in_wdata,
  input constants::lsu_op_type in_lsu_op,
  output logic reg_wren,
  output logic [constants::reg_addr_w-1:0] reg_waddr,
  output logic [constants::xlen-1:0] reg_wdata
);
  import wires::*;

  execute_out_type in_instr;

  mem_if mem_bus ();
  lsu_if lsu_bus ();

  // pack the execute side ports.
  assign in_instr.wren = in_wren;
  assign in_instr.waddr = in_waddr;
  assign in_instr.load = in_load;
  assign in_instr.store = in_store;
  assign in_instr.fence = in_fence;
  assign in_instr.address = in_address;
  assign in_instr.sdata = in_sdata;
  assign in_instr.wdata = in_wdata;
  assign in_instr.lsu_op = in_lsu_op;

  memory_stage u_memory_stage (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_instr  (in_instr),
    .flush     (flush),
    .mem       (mem_bus.master),
    .lsu       (lsu_bus.master),
    .reg_wren  (reg_wren),
    .reg_waddr (reg_waddr),
    .reg_wdata (reg_wdata)
  );

  load_store_unit u_load_store_unit (
    .lsu (lsu_bus.slave)
  );

  write_buffer u_write_buffer (
    .clk (clk),
    .rst (rst),
    .mem (mem_bus.slave)
  );

endmodule

`default_nettype wire

// File: design/write_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module write_buffer (
  input logic clk,
  input logic rst,
  mem_if.slave mem
);
  import constants::*;

  logic [ram_addr_w-1:0] q_addr [wb_depth];
  logic [xlen-1:0] q_data [wb_depth];
  logic [strb_w-1:0] q_strb [wb_depth];
  logic [xlen-1:0] ram [2**ram_addr_w];

  logic [wb_ptr_w-1:0] wr_ptr;
  logic [wb_ptr_w-1:0] rd_ptr;
  logic [wb_ptr_w:0] count;
  logic full;
  logic empty;
  logic is_store;
  logic push;
  logic pop;

  // ##########################################################################
  // ready rule.
  // ##########################################################################

  assign full = (count == wb_depth);
  assign empty = (count == 0);
  assign is_store = (|mem.mem_wstrb) & ~mem.mem_fence;

  // loads and fences see ram only once every store has drained.
  assign mem.mem_ready = is_store ? ~full : empty;
  assign mem.mem_rdata = ram[mem.mem_addr[ram_addr_w+1:2]];

  assign push = mem.mem_valid & mem.mem_ready & is_store;
  assign pop = ~empty; // drain one entry every cycle.

  // ##########################################################################
  // queue and drain.
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_addr[wr_ptr] <= mem.mem_addr[ram_addr_w+1:2];
      q_data[wr_ptr] <= mem.mem_wdata;
      q_strb[wr_ptr] <= mem.mem_wstrb;
    end
  end

  // only strobed bytes of the oldest entry are written.
  always_ff @(posedge clk) begin
    if (pop) begin
      for (int i = 0; i < strb_w; i++) begin
        if (q_strb[rd_ptr][i]) begin
          ram[q_addr[rd_ptr]][8*i +: 8] <= q_data[rd_ptr][8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/load_store_unit.sv
`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
  lsu_if.slave lsu
);
  import constants::*;

  word_lanes_type word;
  logic [7:0] byte_val;
  logic [15:0] half_val;

  always_comb begin
    word = lsu.ldata;

    // the byte enable names the lane.
    byte_val = word.lane_b[0];
    if (lsu.byteenable[1]) byte_val = word.lane_b[1];
    if (lsu.byteenable[2]) byte_val = word.lane_b[2];
    if (lsu.byteenable[3]) byte_val = word.lane_b[3];
    half_val = lsu.byteenable[2] ? word.lane_h[1] : word.lane_h[0];

    if (lsu.lsu_op.lsu_lb) begin
      lsu.result = {{(xlen-8){byte_val[7]}}, byte_val};
    end else if (lsu.lsu_op.lsu_lbu) begin
      lsu.result = {{(xlen-8){1'b0}}, byte_val};
    end else if (lsu.lsu_op.lsu_lh) begin
      lsu.result = {{(xlen-16){half_val[15]}}, half_val};
    end else if (lsu.lsu_op.lsu_lhu) begin
      lsu.result = {{(xlen-16){1'b0}}, half_val};
    end else begin
      lsu.result = word; // lsu_lw.
    end
  end

endmodule

`default_nettype wire

// File: design/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
  input logic clk,
  input logic rst,
  input logic in_valid,
  output logic in_ready,
  input wires::execute_out_type in_instr,
  input logic flush,
  mem_if.master mem,
  lsu_if.master lsu,
  output logic reg_wren,
  output logic [constants::reg_addr_w-1:0] reg_waddr,
  output logic [constants::xlen-1:0] reg_wdata
);
  import constants::*;
  import wires::*;

  memory_reg_type r, v;
  logic [strb_w-1:0] byteenable;
  logic [xlen-1:0] st_data;
  logic is_mem;
  logic stall;
  logic done;

  // ##########################################################################
  // lane alignment.
  // ##########################################################################

  always_comb begin
    if (r.lsu_op.lsu_lb | r.lsu_op.lsu_lbu | r.lsu_op.lsu_sb) begin
      byteenable = 4'b0001 << r.address[1:0];
    end else if (r.lsu_op.lsu_lh | r.lsu_op.lsu_lhu | r.lsu_op.lsu_sh) begin
      byteenable = 4'b0011 << {r.address[1], 1'b0};
    end else begin
      byteenable = 4'b1111;
    end

    if (r.lsu_op.lsu_sb) begin
      st_data = {4{r.sdata[7:0]}}; // copy the byte into every lane.
    end else if (r.lsu_op.lsu_sh) begin
      st_data = {2{r.sdata[15:0]}};
    end else begin
      st_data = r.sdata;
    end
  end

  // ##########################################################################
  // request and completion.
  // ##########################################################################

  assign is_mem = r.load | r.store | r.fence;

  // a fresh request under flush is never presented.
  assign mem.mem_valid = r.valid & is_mem & (r.issued | ~flush);
  assign mem.mem_fence = r.fence;
  assign mem.mem_addr = r.address;
  assign mem.mem_wdata = st_data;
  assign mem.mem_wstrb = r.store ? byteenable : '0;

  assign lsu.ldata = mem.mem_rdata;
  assign lsu.byteenable = byteenable;
  assign lsu.lsu_op = r.lsu_op;

  assign stall = r.valid & is_mem & ~mem.mem_ready;
  assign done = r.valid & ~stall;
  assign in_ready = ~r.valid | done;

  assign reg_wren = done & r.wren & (|r.waddr) & ~flush;
  assign reg_waddr = r.waddr;
  assign reg_wdata = r.load ? lsu.result : r.wdata;

  always_comb begin
    v = r;
    if (stall & ~flush) v.issued = 1'b1; // hold until ready.
    if (done | flush) v.valid = 1'b0;
    if (in_valid & in_ready) begin
      v.valid = 1'b1;
      v.issued = 1'b0;
      v.wren = in_instr.wren;
      v.waddr = in_instr.waddr;
      v.load = in_instr.load;
      v.store = in_instr.store;
      v.fence = in_instr.fence;
      v.address = in_instr.address;
      v.sdata = in_instr.sdata;
      v.wdata = in_instr.wdata;
      v.lsu_op = in_instr.lsu_op;
    end
  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      r <= init_memory_reg;
    end else begin
      r <= v;
    end
  end

endmodule

`default_nettype wire

// File: design/mem_if.sv
`timescale 1ns/1ns
`default_nettype none

// stage to write buffer request, a zero strobe means a load.
interface mem_if;
  import constants::*;

  logic mem_valid;
  logic mem_fence;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] mem_wdata;
  logic [strb_w-1:0] mem_wstrb;
  logic mem_ready;
  logic [xlen-1:0] mem_rdata;

  modport master (output mem_valid, mem_fence, mem_addr, mem_wdata, mem_wstrb,
                  input mem_ready, mem_rdata);
  modport slave (input mem_valid, mem_fence, mem_addr, mem_wdata, mem_wstrb,
                 output mem_ready, mem_rdata);
endinterface

// stage to load-store unit, purely combinational.
interface lsu_if;
  import constants::*;

  logic [xlen-1:0] ldata;
  logic [strb_w-1:0] byteenable;
  lsu_op_type lsu_op;
  logic [xlen-1:0] result;

  modport master (output ldata, byteenable, lsu_op, input result);
  modport slave (input ldata, byteenable, lsu_op, output result);
endinterface

`default_nettype wire

// File: design/wires.sv
`default_nettype none

package wires;

  import constants::*;

  // one instruction handed over from execute.
  typedef struct packed {
    logic wren;
    logic [reg_addr_w-1:0] waddr;
    logic load;
    logic store;
    logic fence;
    logic [xlen-1:0] address; // byte address.
    logic [xlen-1:0] sdata;   // store data, not yet lane aligned.
    logic [xlen-1:0] wdata;   // alu result.
    lsu_op_type lsu_op;
  } execute_out_type;

  // memory stage register.
  typedef struct packed {
    logic valid;
    logic issued; // request presented and still waiting for ready.
    logic wren;
    logic [reg_addr_w-1:0] waddr;
    logic load;
    logic store;
    logic fence;
    logic [xlen-1:0] address;
    logic [xlen-1:0] sdata;
    logic [xlen-1:0] wdata;
    lsu_op_type lsu_op;
  } memory_reg_type;

  localparam memory_reg_type init_memory_reg = '0;

endpackage

`default_nettype wire

// File: design/constants.sv
`default_nettype none

package constants;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int ram_addr_w = 8; // 256 words of data ram.
  localparam int strb_w = xlen / 8;
  localparam int wb_depth = 4;
  localparam int wb_ptr_w = $clog2(wb_depth);

  // one-hot load and store operation flags.
  typedef struct packed {
    logic lsu_lb;
    logic lsu_lh;
    logic lsu_lw;
    logic lsu_lbu;
    logic lsu_lhu;
    logic lsu_sb;
    logic lsu_sh;
    logic lsu_sw;
  } lsu_op_type;

  // one word seen as byte lanes or as halfword lanes.
  typedef union packed {
    logic [3:0][7:0] lane_b;
    logic [1:0][15:0] lane_h;
  } word_lanes_type;

endpackage

`default_nettype wire
